//--- Makefile
# Verilator build and run for the arcade game core testbench

VERILATOR ?= verilator
TOP       ?= tb_game
FILELIST  ?= arcade_game.f
BUILD_DIR ?= obj_dir
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -j 0

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run build lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- arcade_game.f
src/arcade_pkg.sv
src/game_prog.sv
src/game_rom_fetch.sv
src/game_video.sv
src/game_top.sv
tests/tb_game_check.sv
tests/tb_game.sv

//--- src/arcade_pkg.sv
// Shared sizes, raster timing, palette, bus structs and FSM enums of the game core
package arcade_pkg;

    // SDRAM and ROM layout
    localparam int SDRAM_AW   = 22;
    localparam int ROM_BYTES  = 4096;
    localparam int MAIN_AW    = 10;
    localparam int GFX_AW     = 10;
    localparam int GFX_OFFSET = 1024;

    // Raster timing, counted in pixels and lines
    localparam int CEN_DIV         = 4;
    localparam int H_TOTAL         = 64;
    localparam int H_VISIBLE       = 48;
    localparam int H_SYNC_START    = 52;
    localparam int H_SYNC_END      = 56;
    localparam int V_TOTAL         = 40;
    localparam int V_VISIBLE       = 32;
    localparam int V_SYNC_START    = 34;
    localparam int V_SYNC_END      = 36;
    localparam int GROUPS_PER_LINE = 12;

    // RGB 4:4:4, entry 15 listed first
    localparam logic [15:0][11:0] PALETTE = {
        12'hfff, 12'hccc, 12'h888, 12'h444,
        12'hf0f, 12'h0ff, 12'hff0, 12'hf80,
        12'h08f, 12'h8f0, 12'hf08, 12'h00f,
        12'h0f0, 12'hf00, 12'h123, 12'h000
    };

    typedef struct packed {
        logic [SDRAM_AW-1:0] addr;
        logic [7:0]          data;
        logic [1:0]          mask;  // active low, bit 0 is the low byte
        logic                we;
    } prog_t;

    // Both slots use the same word address width
    typedef struct packed {
        logic               cs;
        logic [MAIN_AW-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } rom_rsp_t;

    typedef struct packed {
        logic                req;
        logic [SDRAM_AW-1:0] addr;
        logic                refresh_en;
    } sdram_req_t;

    typedef struct packed {
        logic       hbl;
        logic       vbl;
        logic       hs;
        logic       vs;
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } video_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT_ACK,
        FETCH_WAIT_DATA
    } fetch_state_e;

    typedef enum logic {
        SLOT_GFX,
        SLOT_MAIN
    } slot_e;

endpackage

//--- src/game_prog.sv
// Loader byte stream to masked SDRAM word writes, with ROM size filter
`timescale 1ns/1ns

module game_prog import arcade_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        ioctl_wr,
    input  logic [21:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    output prog_t       prog
);

    logic                in_rom;
    logic                accept;
    logic                we_q;
    logic [SDRAM_AW-1:0] addr_q;
    logic [7:0]          data_q;
    logic [1:0]          mask_q;

    // Anything past the ROM image is thrown away
    assign in_rom = ioctl_addr < 22'(ROM_BYTES);
    assign accept = ioctl_wr && in_rom;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            we_q <= 1'b0;
        end else begin
            we_q <= accept;
        end
    end

    // Byte address to word address, the odd byte lands in the upper half
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= {1'b0, ioctl_addr[21:1]};
            data_q <= ioctl_data;
            if (ioctl_addr[0]) begin
                mask_q <= 2'b01;
            end else begin
                mask_q <= 2'b10;
            end
        end
    end

    assign prog = '{
        addr: addr_q,
        data: data_q,
        mask: mask_q,
        we:   we_q
    };

endmodule

//--- src/game_rom_fetch.sv
// Two-slot ROM arbiter with per-slot word cache, SDRAM handshake and ready flag
`timescale 1ns/1ns

module game_rom_fetch import arcade_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  rom_req_t    gfx_req,
    input  rom_req_t    main_req,
    output rom_rsp_t    gfx_rsp,
    output rom_rsp_t    main_rsp,
    output sdram_req_t  sdram,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [15:0] data_read,
    output logic        ready
);

    rom_req_t [1:0]     client;
    logic [MAIN_AW-1:0] cache_addr [2];
    logic [15:0]        cache_data [2];
    logic [1:0]         cache_valid;
    logic [1:0]         hit;
    logic [1:0]         miss;
    fetch_state_e       state;
    slot_e              sel;
    slot_e              pick;
    logic               launch;
    logic               fill;
    logic [MAIN_AW-1:0] fill_addr;
    logic               req_q;
    logic [SDRAM_AW-1:0] req_addr;
    logic [1:0]         ready_sr;

    assign client[SLOT_GFX]  = gfx_req;
    assign client[SLOT_MAIN] = main_req;

    // Hit when the cached word belongs to the address the client holds now
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            hit[i]  = client[i].cs && cache_valid[i] && cache_addr[i] == client[i].addr;
            miss[i] = client[i].cs && !hit[i];
        end
    end

    // Video must never stall, so graphics goes first
    assign pick   = miss[SLOT_GFX] ? SLOT_GFX : SLOT_MAIN;
    assign launch = state == FETCH_IDLE && !downloading && |miss;
    assign fill   = state == FETCH_WAIT_DATA && data_rdy;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= FETCH_IDLE;
            sel   <= SLOT_GFX;
            req_q <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (launch) begin
                        sel   <= pick;
                        req_q <= 1'b1;
                        state <= FETCH_WAIT_ACK;
                    end
                end
                FETCH_WAIT_ACK: begin
                    if (sdram_ack) begin
                        req_q <= 1'b0;
                        state <= FETCH_WAIT_DATA;
                    end
                end
                FETCH_WAIT_DATA: begin
                    if (data_rdy) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: begin
                    req_q <= 1'b0;
                    state <= FETCH_IDLE;
                end
            endcase
        end
    end

    // Download overwrites the ROM, nothing cached can be trusted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cache_valid <= '0;
        end else if (downloading) begin
            cache_valid <= '0;
        end else if (fill) begin
            cache_valid[sel] <= 1'b1;
        end
    end

    // Address is frozen from launch until the ack
    always_ff @(posedge clk) begin
        if (launch) begin
            fill_addr <= client[pick].addr;
            if (pick == SLOT_GFX) begin
                req_addr <= SDRAM_AW'(client[pick].addr) + SDRAM_AW'(GFX_OFFSET);
            end else begin
                req_addr <= SDRAM_AW'(client[pick].addr);
            end
        end
        if (fill) begin
            cache_addr[sel] <= fill_addr;
            cache_data[sel] <= data_read;
        end
    end

    // Two flops after the end of the download
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_sr <= 2'b00;
        end else begin
            ready_sr <= {ready_sr[0], !downloading};
        end
    end

    assign ready = ready_sr[1] && !downloading;

    assign gfx_rsp  = '{ok: hit[SLOT_GFX] && !downloading, data: cache_data[SLOT_GFX]};
    assign main_rsp = '{ok: hit[SLOT_MAIN] && !downloading, data: cache_data[SLOT_MAIN]};

    // Refresh only goes in when no access is pending
    assign sdram = '{
        req:        req_q,
        addr:       req_addr,
        refresh_en: state == FETCH_IDLE
    };

endmodule

//--- src/game_top.sv
// Game core top: ROM download, ROM fetch arbiter and video, held off until ROM is ready
`timescale 1ns/1ns

module game_top import arcade_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic [21:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    output prog_t       prog,
    output sdram_req_t  sdram,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [15:0] data_read,
    input  rom_req_t    main_req,
    output rom_rsp_t    main_rsp,
    output logic        ready,
    output video_t      video
);

    rom_req_t gfx_req;
    rom_rsp_t gfx_rsp;
    logic     game_rst;

    // Game logic sits in reset until the ROM image is in place
    assign game_rst = !ready;

    game_prog u_prog (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .ioctl_wr   ( ioctl_wr   ),
        .ioctl_addr ( ioctl_addr ),
        .ioctl_data ( ioctl_data ),
        .prog       ( prog       )
    );

    game_rom_fetch u_fetch (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .gfx_req     ( gfx_req     ),
        .main_req    ( main_req    ),
        .gfx_rsp     ( gfx_rsp     ),
        .main_rsp    ( main_rsp    ),
        .sdram       ( sdram       ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .ready       ( ready       )
    );

    game_video u_video (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .game_rst ( game_rst ),
        .gfx_req  ( gfx_req  ),
        .gfx_rsp  ( gfx_rsp  ),
        .video    ( video    )
    );

endmodule

//--- src/game_video.sv
// Pixel enable, H/V timing, syncs, graphics word prefetch and palette output
`timescale 1ns/1ns

module game_video import arcade_pkg::*; (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     game_rst,
    output rom_req_t gfx_req,
    input  rom_rsp_t gfx_rsp,
    output video_t   video
);

    logic [$clog2(CEN_DIV)-1:0] cen_cnt;
    logic                       pxl_cen;
    logic [$clog2(H_TOTAL)-1:0] h_cnt;
    logic [$clog2(H_TOTAL)-1:0] h_nxt;
    logic [$clog2(V_TOTAL)-1:0] v_cnt;
    logic [$clog2(V_TOTAL)-1:0] v_nxt;
    logic [$clog2(V_TOTAL)-1:0] v_inc;
    logic                       grp_start;
    logic                       line_pre;
    logic [GFX_AW-1:0]          gfx_addr;
    logic [GFX_AW-1:0]          gfx_addr_nxt;
    logic                       gfx_cs;
    logic [15:0]                pix_sr;
    logic                       pix_ok;
    logic [11:0]                colour;
    video_t                     vid_d;

    assign pxl_cen = int'(cen_cnt) == CEN_DIV - 1;

    always_comb begin
        v_inc = (int'(v_cnt) == V_TOTAL - 1) ? '0 : v_cnt + 1'b1;
        if (int'(h_cnt) == H_TOTAL - 1) begin
            h_nxt = '0;
            v_nxt = v_inc;
        end else begin
            h_nxt = h_cnt + 1'b1;
            v_nxt = v_cnt;
        end
    end

    // Judged on the counter value about to be loaded
    assign grp_start = pxl_cen && h_nxt[1:0] == 2'd0 && int'(h_nxt) < H_VISIBLE;
    assign line_pre  = pxl_cen && int'(h_nxt) == H_TOTAL - 4;

    // One group ahead, group 0 of the next line goes out during hblank
    always_comb begin
        gfx_addr_nxt = gfx_addr;
        if (grp_start) begin
            gfx_addr_nxt = GFX_AW'(v_nxt) * GFX_AW'(GROUPS_PER_LINE)
                         + GFX_AW'(h_nxt >> 2) + 1'b1;
        end else if (line_pre) begin
            gfx_addr_nxt = GFX_AW'(v_inc) * GFX_AW'(GROUPS_PER_LINE);
        end
    end

    assign colour = PALETTE[pix_sr[3:0]];

    always_comb begin
        vid_d.hbl = int'(h_cnt) >= H_VISIBLE;
        vid_d.vbl = int'(v_cnt) >= V_VISIBLE;
        vid_d.hs  = int'(h_cnt) >= H_SYNC_START && int'(h_cnt) < H_SYNC_END;
        vid_d.vs  = int'(v_cnt) >= V_SYNC_START && int'(v_cnt) < V_SYNC_END;
        // Late word or blanking gives black
        if (!vid_d.hbl && !vid_d.vbl && pix_ok) begin
            {vid_d.red, vid_d.green, vid_d.blue} = colour;
        end else begin
            {vid_d.red, vid_d.green, vid_d.blue} = 12'h000;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_cnt  <= '0;
            h_cnt    <= '0;
            v_cnt    <= '0;
            gfx_cs   <= 1'b0;
            gfx_addr <= GFX_AW'(1);
            pix_ok   <= 1'b0;
            video    <= '{hbl: 1'b1, vbl: 1'b1, hs: 1'b0, vs: 1'b0,
                          red: 4'h0, green: 4'h0, blue: 4'h0};
        end else if (game_rst) begin
            cen_cnt  <= '0;
            h_cnt    <= '0;
            v_cnt    <= '0;
            gfx_cs   <= 1'b0;
            gfx_addr <= GFX_AW'(1);
            pix_ok   <= 1'b0;
            video    <= '{hbl: 1'b1, vbl: 1'b1, hs: 1'b0, vs: 1'b0,
                          red: 4'h0, green: 4'h0, blue: 4'h0};
        end else begin
            cen_cnt  <= pxl_cen ? '0 : cen_cnt + 1'b1;
            gfx_cs   <= 1'b1;
            gfx_addr <= gfx_addr_nxt;
            if (pxl_cen) begin
                h_cnt <= h_nxt;
                v_cnt <= v_nxt;
                video <= vid_d;
            end
            if (grp_start) begin
                pix_ok <= gfx_rsp.ok;
            end
        end
    end

    // Lowest nibble is shown first
    always_ff @(posedge clk) begin
        if (grp_start) begin
            pix_sr <= gfx_rsp.data;
        end else if (pxl_cen) begin
            pix_sr <= pix_sr >> 4;
        end
    end

    assign gfx_req = '{cs: gfx_cs, addr: MAIN_AW'(gfx_addr)};

endmodule

//--- tests/tb_game.sv
// Testbench top: clock, reset, SDRAM model, ROM loader, CPU slot stimulus and timeout
`timescale 1ns/1ns

module tb_game import arcade_pkg::*; ();

    localparam int FRAME_CYCLES = V_TOTAL * H_TOTAL * CEN_DIV;
    localparam int TIMEOUT      = 3 * FRAME_CYCLES + 8 * ROM_BYTES + 20000;
    localparam int SDRAM_WORDS  = 2048;

    logic        clk;
    logic        arst_n;
    logic        downloading;
    logic        ioctl_wr;
    logic [21:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    prog_t       prog;
    sdram_req_t  sdram;
    logic        sdram_ack;
    logic        data_rdy;
    logic [15:0] data_read;
    rom_req_t    main_req;
    rom_rsp_t    main_rsp;
    logic        ready;
    video_t      video;
    logic        run_done;
    logic        report_done;
    logic        frames_done;
    int          errors;
    int          cycles;
    logic [15:0] sdram_mem [SDRAM_WORDS];

    game_top i_game_top (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog        ( prog        ),
        .sdram       ( sdram       ),
        .sdram_ack   ( sdram_ack   ),
        .data_rdy    ( data_rdy    ),
        .data_read   ( data_read   ),
        .main_req    ( main_req    ),
        .main_rsp    ( main_rsp    ),
        .ready       ( ready       ),
        .video       ( video       )
    );

    tb_game_check i_check (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .downloading ( downloading ),
        .ioctl_wr    ( ioctl_wr    ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .prog        ( prog        ),
        .sdram       ( sdram       ),
        .data_rdy    ( data_rdy    ),
        .main_req    ( main_req    ),
        .main_rsp    ( main_rsp    ),
        .ready       ( ready       ),
        .video       ( video       ),
        .run_done    ( run_done    ),
        .errors      ( errors      ),
        .report_done ( report_done )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // SDRAM contents before the download, pattern over the whole address
    initial begin
        for (int i = 0; i < SDRAM_WORDS; i++) begin
            sdram_mem[i] = 16'(i * 40503) ^ 16'h3c5a;
        end
    end

    // Byte writes from the download path, mask is active low
    always @(negedge clk) begin
        if (prog.we) begin
            if (!prog.mask[0]) begin
                sdram_mem[prog.addr[10:0]][7:0] = prog.data;
            end
            if (!prog.mask[1]) begin
                sdram_mem[prog.addr[10:0]][15:8] = prog.data;
            end
        end
    end

    task automatic serve_request();
        logic [10:0] addr;
        int          delay;
        addr  = sdram.addr[10:0];
        delay = 1 + int'($urandom % 3);
        repeat (delay - 1) @(negedge clk);
        sdram_ack = 1'b1;
        @(negedge clk);
        sdram_ack = 1'b0;
        delay = 1 + int'($urandom % 3);
        repeat (delay - 1) @(negedge clk);
        data_read = sdram_mem[addr];
        data_rdy  = 1'b1;
        @(negedge clk);
        data_rdy = 1'b0;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (sdram.req) begin
                serve_request();
            end
        end
    end

    task automatic load_rom();
        for (int a = 0; a < ROM_BYTES + 16; a++) begin
            ioctl_wr   = 1'b1;
            ioctl_addr = 22'(a);
            ioctl_data = 8'($urandom);
            @(negedge clk);
            ioctl_wr = 1'b0;
            repeat ($urandom % 3) @(negedge clk);
        end
    endtask

    // Random CPU reads until the frames are done, about a third repeat the previous address
    task automatic cpu_reads();
        logic [MAIN_AW-1:0] addr;
        int                 n;
        addr = '0;
        n    = 0;
        while (!frames_done) begin
            if (n == 0 || $urandom % 3 != 0) begin
                addr = MAIN_AW'($urandom);
            end
            n++;
            main_req = '{cs: 1'b1, addr: addr};
            do begin
                @(posedge clk);
            end while (!main_rsp.ok);
            @(negedge clk);
            main_req.cs = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic wait_frames(input int count);
        repeat (count) @(posedge video.vs);
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= TIMEOUT) begin
                $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT);
                $display("Something failed");
                $finish;
            end
        end
    end

    initial begin
        void'($urandom(10));
        arst_n      = 1'b0;
        downloading = 1'b1;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        sdram_ack   = 1'b0;
        data_rdy    = 1'b0;
        data_read   = '0;
        main_req    = '0;
        run_done    = 1'b0;
        frames_done = 1'b0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);
        // CPU slot already asks for a word while the ROM is loading
        main_req = '{cs: 1'b1, addr: MAIN_AW'($urandom)};
        load_rom();
        downloading = 1'b0;
        main_req.cs = 1'b0;
        while (!ready) @(negedge clk);
        fork
            cpu_reads();
            begin
                wait_frames(3);
                frames_done = 1'b1;
            end
        join
        run_done = 1'b1;
        wait (report_done);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tests/tb_game_check.sv
// Checker: reference models for download and pixels, port comparisons and test report
`timescale 1ns/1ns

module tb_game_check import arcade_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  logic [21:0] ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  prog_t       prog,
    input  sdram_req_t  sdram,
    input  logic        data_rdy,
    input  rom_req_t    main_req,
    input  rom_rsp_t    main_rsp,
    input  logic        ready,
    input  video_t      video,
    input  logic        run_done,
    output int          errors,
    output logic        report_done
);

    localparam int NT = 6;
    localparam int LINE_CYCLES = H_TOTAL * CEN_DIV;

    string        names [NT] = '{"reset", "download", "ready", "main_reads", "timing", "pixels"};
    int           checks [NT];
    int           fails [NT];
    logic [7:0]   rom_img [ROM_BYTES];
    logic         wr_q = 1'b0;
    logic [21:0]  addr_q;
    logic [7:0]   data_q;
    logic         dl_q = 1'b1;
    logic         ready_armed = 1'b0;
    int           since_dl;
    logic         cs_q = 1'b0;
    logic         first;
    logic         repeat_req = 1'b0;
    logic         have_last = 1'b0;
    logic [MAIN_AW-1:0] last_addr;
    logic         pend = 1'b0;
    logic [3:0]   sig;
    logic [3:0]   sig_q = 4'b0011;
    logic [3:0]   armed = '0;
    int           run_len [4];
    int           exp_len [4];
    int           hs_period = 0;
    int           hs_count = 0;
    logic         hs_seen = 1'b0;
    logic         vs_seen = 1'b0;
    int           frame = 0;
    int           line = 0;
    int           pix_cyc = 0;

    initial begin
        exp_len[0] = (H_TOTAL - H_VISIBLE) * CEN_DIV;
        exp_len[1] = (V_TOTAL - V_VISIBLE) * LINE_CYCLES;
        exp_len[2] = (H_SYNC_END - H_SYNC_START) * CEN_DIV;
        exp_len[3] = (V_SYNC_END - V_SYNC_START) * LINE_CYCLES;
        errors      = 0;
        report_done = 1'b0;
    end

    task automatic check(input int t, input bit good, input string msg);
        checks[t]++;
        if (!good) begin
            fails[t]++;
            $display("Fail at %0t ns: %s: %s", $time, names[t], msg);
        end
    endtask

    task automatic test_line(input int t);
        if (checks[t] == 0) begin
            fails[t]++;
            $display("Test %s ran no checks at all", names[t]);
        end
        $display("Test %s finished: %0d checks, %0d errors", names[t], checks[t], fails[t]);
    endtask

    // Even byte goes to the low half, odd byte to the high half
    function automatic prog_t expected_prog(input logic [21:0] addr, input logic [7:0] data);
        prog_t p;
        p.addr = SDRAM_AW'(addr / 2);
        p.data = data;
        p.mask = (addr % 2 == 0) ? 2'b10 : 2'b01;
        p.we   = 1'b1;
        return p;
    endfunction

    function automatic logic [15:0] rom_word(input int a);
        return {rom_img[2 * a + 1], rom_img[2 * a]};
    endfunction

    // Group g of a line shows the word at line * groups + g, lowest nibble first
    function automatic logic [11:0] expected_pixel(input int v, input int h);
        logic [15:0] w;
        int          n;
        w = rom_word(GFX_OFFSET + v * GROUPS_PER_LINE + h / 4);
        n = int'(w >> (4 * (h % 4))) & 15;
        return PALETTE[n];
    endfunction

    initial begin
        @(posedge arst_n);
        @(posedge clk);
        check(0, prog.we == 1'b0 && sdram.req == 1'b0 && main_rsp.ok == 1'b0,
              "prog we, sdram req or main ok not low");
        check(0, ready == 1'b0 && video.hs == 1'b0 && video.vs == 1'b0, "ready or syncs not low");
        check(0, {video.red, video.green, video.blue} == 12'h000, "colour not black");
        check(0, video.hbl && video.vbl, "blanking not high");
        test_line(0);
    end

    always @(posedge clk) begin
        if (arst_n) begin
            // Download path, one cycle behind the loader
            if (wr_q && addr_q < ROM_BYTES) begin
                check(1, prog == expected_prog(addr_q, data_q),
                      $sformatf("byte %0d gave prog %h", addr_q, prog));
            end else if (prog.we) begin
                check(1, 1'b0, $sformatf("write at word %0d with no loader byte", prog.addr));
            end
            if (downloading && sdram.req) begin
                check(1, 1'b0, "SDRAM request while downloading");
            end
            if (ioctl_wr && ioctl_addr < ROM_BYTES) begin
                rom_img[ioctl_addr] = ioctl_data;
            end
            wr_q   <= ioctl_wr;
            addr_q <= ioctl_addr;
            data_q <= ioctl_data;

            // Ready delay counted from the first edge with the download over
            if (dl_q && !downloading) begin
                test_line(1);
                since_dl    = 0;
                ready_armed = 1'b1;
            end else begin
                since_dl++;
            end
            if (ready_armed) begin
                if (since_dl < 2) begin
                    check(2, !ready, $sformatf("ready high %0d cycles after download", since_dl));
                end else begin
                    check(2, ready, "ready still low 2 cycles after download");
                    test_line(2);
                    ready_armed = 1'b0;
                end
            end
            dl_q <= downloading;

            // Refresh only while no SDRAM access is in flight
            check(3, sdram.refresh_en == !(sdram.req || pend),
                  $sformatf("refresh_en %b with req %b and data pending %b",
                            sdram.refresh_en, sdram.req, pend));
            if (sdram.req) begin
                pend = 1'b1;
            end
            if (data_rdy) begin
                pend = 1'b0;
            end

            // CPU slot
            first = main_req.cs && !cs_q;
            if (first) begin
                repeat_req = have_last && main_req.addr == last_addr;
            end
            if (main_req.cs && main_rsp.ok) begin
                check(3, main_rsp.data == rom_word(int'(main_req.addr)),
                      $sformatf("word %0d read %h", main_req.addr, main_rsp.data));
                if (repeat_req) begin
                    check(3, first, $sformatf("repeat of word %0d went to SDRAM", main_req.addr));
                end
                last_addr = main_req.addr;
                have_last = 1'b1;
            end
            cs_q <= main_req.cs;
        end

        if (arst_n && ready) begin
            sig = {video.vs, video.hs, video.vbl, video.hbl};
            // Pulse widths, the first pulse after reset is partial
            for (int i = 0; i < 4; i++) begin
                if (sig[i] && !sig_q[i]) begin
                    run_len[i] = 1;
                    armed[i]   = 1'b1;
                end else if (sig[i]) begin
                    run_len[i]++;
                end else if (sig_q[i] && armed[i]) begin
                    check(4, run_len[i] == exp_len[i],
                          $sformatf("pulse %0d lasted %0d cycles", i, run_len[i]));
                end
            end
            hs_period++;
            if (video.hs && !sig_q[2]) begin
                if (hs_seen) begin
                    check(4, hs_period == LINE_CYCLES, $sformatf("line took %0d cycles", hs_period));
                end
                hs_seen   = 1'b1;
                hs_period = 0;
                hs_count++;
            end
            if (video.vs && !sig_q[3]) begin
                if (vs_seen) begin
                    check(4, hs_count == V_TOTAL, $sformatf("frame had %0d lines", hs_count));
                end
                vs_seen  = 1'b1;
                hs_count = 0;
            end

            // Raster position from the blanking edges
            if (!video.vbl && sig_q[1]) begin
                frame++;
            end
            if (!video.hbl && sig_q[0]) begin
                line    = (!video.vbl && sig_q[1]) ? 0 : line + 1;
                pix_cyc = 0;
            end else begin
                pix_cyc++;
            end
            if (frame >= 2) begin
                if (video.hbl || video.vbl) begin
                    check(5, {video.red, video.green, video.blue} == 12'h000, "blank not black");
                end else begin
                    check(5, {video.red, video.green, video.blue}
                             == expected_pixel(line, pix_cyc / CEN_DIV),
                          $sformatf("pixel %0d of line %0d is %h", pix_cyc / CEN_DIV, line,
                                    {video.red, video.green, video.blue}));
                end
            end
            sig_q = sig;
        end
    end

    initial begin
        int total;
        wait (run_done);
        test_line(3);
        test_line(4);
        test_line(5);
        total = 0;
        for (int t = 0; t < NT; t++) begin
            total  += checks[t];
            errors += fails[t];
        end
        $display("Total: %0d checks, %0d errors", total, errors);
        report_done = 1'b1;
    end

endmodule
